// File: Bender.yml
package:
  name: npc

export_include_dirs:
  - .

sources:
  - files:
      - rv_isa_pkg.sv
      - npc_ctrl_pkg.sv
      - npc_decoder.sv
      - npc_alu.sv
      - npc_regfile.sv
      - npc_fetch.sv
      - npc_top.sv
  - target: test
    files:
      - npc_assertions.sv
      - tb_npc.sv

// File: npc_alu.sv
`timescale 1ns/10ps

module npc_alu
    import rv_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  word_t   pc,
    input  word_t   imm,
    input  word_t   src1,
    input  word_t   src2,
    input  word_t   mem_rdata,
    input  alu_op_t alu_op,
    output word_t   result,
    output word_t   mem_addr
);

    word_t pc_plus_imm;
    word_t pc_plus_4;
    word_t src1_plus_imm;
    word_t src1_plus_src2;
    logic  is_link;

    // adders shared between operations
    assign pc_plus_imm    = pc + imm;
    assign pc_plus_4      = pc + 32'd4;
    assign src1_plus_imm  = src1 + imm;
    assign src1_plus_src2 = src1 + src2;

    // both jumps write the return address
    assign is_link = alu_op[ALU_JAL] | alu_op[ALU_JALR];

    // alu_op is one-hot, so an and-or mux is enough
    assign result = ({32{alu_op[ALU_AUIPC]}} & pc_plus_imm)
                  | ({32{alu_op[ALU_LUI]}}   & imm)
                  | ({32{is_link}}           & pc_plus_4)
                  | ({32{alu_op[ALU_ADDI]}}  & src1_plus_imm)
                  | ({32{alu_op[ALU_ADD]}}   & src1_plus_src2)
                  | ({32{alu_op[ALU_LW]}}    & mem_rdata);

    // load address, driven for every instruction
    assign mem_addr = src1_plus_imm;

endmodule

// File: npc_assertions.sv
`timescale 1ns/10ps
`include "npc_cfg.svh"

module npc_assertions
    import rv_isa_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input word_t inst,
    input word_t dmem_rdata,
    input word_t pc,
    input word_t dmem_addr,
    input logic  dmem_ren,
    input logic  wb_en,
    input word_t wb_data,
    input logic  halted
);

    int fail_count = 0;

    opcode_t opc;
    word_t   u_imm;
    word_t   j_imm;
    word_t   upper_expect;
    logic    is_lui;
    logic    is_auipc;
    logic    is_jal;
    logic    is_jalr;
    logic    is_lw;
    logic    is_ebreak;

    // fields of the presented instruction
    assign opc       = inst[6:0];
    assign u_imm     = {inst[31:12], 12'h000};
    assign j_imm     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign is_lui    = (opc == OPC_LUI);
    assign is_auipc  = (opc == OPC_AUIPC);
    assign is_jal    = (opc == OPC_JAL);
    assign is_jalr   = (opc == OPC_JALR) && (inst[14:12] == F3_JALR);
    assign is_lw     = (opc == OPC_LOAD) && (inst[14:12] == F3_LW);
    assign is_ebreak = (inst == `NPC_EBREAK_WORD);

    assign upper_expect = is_auipc ? pc + u_imm : u_imm;

    reset_state: assert property (@(posedge clk)
        reset |=> (pc == `NPC_RESET_PC) && !halted) else begin
        fail_count++;
        $error("pc or halted wrong after reset");
    end

    upper_value: assert property (@(posedge clk) disable iff (reset)
        !halted && (is_lui || is_auipc) |-> wb_en && (wb_data == upper_expect)) else begin
        fail_count++;
        $error("lui or auipc writeback value wrong");
    end

    load_access: assert property (@(posedge clk) disable iff (reset)
        !halted && is_lw |-> dmem_ren && wb_en && (wb_data == dmem_rdata)) else begin
        fail_count++;
        $error("lw did not return the data word");
    end

    // link value now and target on the next edge
    jal_step: assert property (@(posedge clk) disable iff (reset)
        !reset && !halted && is_jal |-> (wb_data == pc + 32'd4)
        ##1 (pc == $past(pc) + $past(j_imm))) else begin
        fail_count++;
        $error("jal link or target wrong");
    end

    // dmem_addr carries src1 plus imm for every instruction
    jalr_step: assert property (@(posedge clk) disable iff (reset)
        !reset && !halted && is_jalr |-> (wb_data == pc + 32'd4)
        ##1 (pc == {$past(dmem_addr[31:1]), 1'b0})) else begin
        fail_count++;
        $error("jalr link or target wrong");
    end

    plain_step: assert property (@(posedge clk) disable iff (reset)
        !reset && !halted && !is_jal && !is_jalr && !is_ebreak
        |=> pc == $past(pc) + 32'd4) else begin
        fail_count++;
        $error("pc did not advance by four");
    end

    ebreak_halts: assert property (@(posedge clk) disable iff (reset)
        !reset && !halted && is_ebreak |=> halted && $stable(pc)) else begin
        fail_count++;
        $error("ebreak did not halt the core");
    end

    halt_holds: assert property (@(posedge clk) disable iff (reset)
        !reset && halted |-> !wb_en ##1 (halted && $stable(pc))) else begin
        fail_count++;
        $error("halted core moved or wrote a register");
    end

endmodule

// File: npc_cfg.svh
`ifndef NPC_CFG_SVH
`define NPC_CFG_SVH

// address of the first fetch after reset
`define NPC_RESET_PC 32'h8000_0000

// architectural integer registers, x0 included
`define NPC_REG_COUNT 32

// ebreak encoding, compared against the whole instruction word
`define NPC_EBREAK_WORD 32'h0010_0073

`endif

// File: npc_ctrl_pkg.sv
package npc_ctrl_pkg;

    // one-hot ALU operation, one bit per supported instruction
    typedef logic [6:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int ALU_AUIPC = 0;
    localparam int ALU_LUI   = 1;
    localparam int ALU_JAL   = 2;
    localparam int ALU_JALR  = 3;
    localparam int ALU_ADDI  = 4;
    localparam int ALU_ADD   = 5;
    localparam int ALU_LW    = 6;

    // core run state, halted is left only through reset
    typedef enum logic {
        CORE_RUN,
        CORE_HALTED
    } core_state_t;

endpackage

// File: npc_decoder.sv
`timescale 1ns/10ps
`include "npc_cfg.svh"

module npc_decoder
    import rv_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  word_t    inst,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_t  alu_op,
    output logic     reg_wen,
    output logic     mem_ren,
    output logic     is_jal,
    output logic     is_jalr,
    output logic     is_ebreak
);

    opcode_t     opcode;
    funct3_t     funct3;
    logic [6:0]  funct7;
    opcode_hot_t hot_opcode;
    funct3_hot_t hot_funct3;

    logic  is_i;
    logic  is_r;
    logic  is_u;
    logic  is_j;
    word_t imm_i;
    word_t imm_u;
    word_t imm_j;

    // fixed field positions
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign hot_opcode = opcode_hot_t'(1) << opcode;
    assign hot_funct3 = funct3_hot_t'(1) << funct3;

    // format classes
    assign is_i = hot_opcode[OPC_OP_IMM] | hot_opcode[OPC_LOAD] | hot_opcode[OPC_JALR];
    assign is_r = hot_opcode[OPC_OP];
    assign is_u = hot_opcode[OPC_LUI] | hot_opcode[OPC_AUIPC];
    assign is_j = hot_opcode[OPC_JAL];

    // sign-extended immediates per format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // R format carries no immediate, so it falls out as zero
    assign imm = ({32{is_i}} & imm_i)
               | ({32{is_u}} & imm_u)
               | ({32{is_j}} & imm_j);

    // one strobe per recognised instruction
    assign alu_op[ALU_AUIPC] = is_u & hot_opcode[OPC_AUIPC];
    assign alu_op[ALU_LUI]   = is_u & hot_opcode[OPC_LUI];
    assign alu_op[ALU_JAL]   = is_j;
    assign alu_op[ALU_JALR]  = is_i & hot_opcode[OPC_JALR] & hot_funct3[F3_JALR];
    assign alu_op[ALU_ADDI]  = is_i & hot_opcode[OPC_OP_IMM] & hot_funct3[F3_ADD];
    // sub and friends share funct3 with add, funct7 tells them apart
    assign alu_op[ALU_ADD]   = is_r & hot_funct3[F3_ADD] & (funct7 == 7'b0);
    assign alu_op[ALU_LW]    = is_i & hot_opcode[OPC_LOAD] & hot_funct3[F3_LW];

    // control strobes
    assign reg_wen   = |alu_op;
    assign mem_ren   = alu_op[ALU_LW];
    assign is_jal    = alu_op[ALU_JAL];
    assign is_jalr   = alu_op[ALU_JALR];
    assign is_ebreak = (inst == `NPC_EBREAK_WORD);

endmodule

// File: npc_fetch.sv
`timescale 1ns/10ps
`include "npc_cfg.svh"

module npc_fetch
    import rv_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t imm,
    input  word_t src1,
    input  logic  is_jal,
    input  logic  is_jalr,
    input  logic  is_ebreak,
    output word_t pc,
    output logic  halted
);

    core_state_t state;
    word_t       jalr_target;
    word_t       pc_next;

    assign jalr_target = src1 + imm;

    // next pc, jalr target has bit 0 cleared
    always_comb begin
        if (is_jal) begin
            pc_next = pc + imm;
        end else if (is_jalr) begin
            pc_next = {jalr_target[31:1], 1'b0};
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // pc only moves in run state
    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= `NPC_RESET_PC;
            state <= CORE_RUN;
        end else begin
            case (state)
                CORE_RUN: begin
                    if (is_ebreak) begin
                        // keep the pc on the ebreak itself
                        state <= CORE_HALTED;
                    end else begin
                        pc <= pc_next;
                    end
                end
                default: begin
                    state <= CORE_HALTED;
                end
            endcase
        end
    end

    assign halted = (state == CORE_HALTED);

endmodule

// File: npc_regfile.sv
`timescale 1ns/10ps
`include "npc_cfg.svh"

module npc_regfile
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`NPC_REG_COUNT];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, x0 forced to zero
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// File: npc_top.sv
`timescale 1ns/10ps

module npc_top
    import rv_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    inst,
    input  word_t    dmem_rdata,
    output word_t    pc,
    output word_t    dmem_addr,
    output logic     dmem_ren,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     halted
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    word_t    src1;
    word_t    src2;
    alu_op_t  alu_op;
    logic     reg_wen;
    logic     is_jal;
    logic     is_jalr;
    logic     is_ebreak;

    npc_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .imm       (imm),
        .src1      (src1),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .is_ebreak (is_ebreak),
        .pc        (pc),
        .halted    (halted)
    );

    npc_decoder u_decoder (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (wb_rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .reg_wen   (reg_wen),
        .mem_ren   (dmem_ren),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .is_ebreak (is_ebreak)
    );

    // no register writes once the core has halted
    assign wb_en = reg_wen & ~halted;

    npc_regfile u_regfile (
        .clk    (clk),
        .wen    (wb_en),
        .waddr  (wb_rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    npc_alu u_alu (
        .pc        (pc),
        .imm       (imm),
        .src1      (src1),
        .src2      (src2),
        .mem_rdata (dmem_rdata),
        .alu_op    (alu_op),
        .result    (wb_data),
        .mem_addr  (dmem_addr)
    );

endmodule

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // data word, also used for pc, immediates and results
    typedef logic [31:0] word_t;

    // register index into the 32-entry file
    typedef logic [4:0] reg_idx_t;

    // raw opcode and funct3 fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // one-hot decodes of opcode and funct3
    typedef logic [127:0] opcode_hot_t;
    typedef logic [7:0] funct3_hot_t;

    // major opcodes of the supported subset
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;

    // funct3 values used by the subset
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_JALR = 3'b000;
    localparam funct3_t F3_LW   = 3'b010;

endpackage

// File: src.f
+incdir+.
rv_isa_pkg.sv
npc_ctrl_pkg.sv
npc_decoder.sv
npc_alu.sv
npc_regfile.sv
npc_fetch.sv
npc_top.sv
npc_assertions.sv
tb_npc.sv

// File: tb_npc.sv
`timescale 1ns/10ps
`include "npc_cfg.svh"

module tb_npc
    import rv_isa_pkg::*;
();

    localparam int RAND_SEED   = 83154;
    localparam int RUN_TIMEOUT = 200;
    localparam int HALT_WINDOW = 8;
    localparam int IMEM_DEPTH  = 32;
    localparam int DMEM_DEPTH  = 64;
    localparam int NUM_TESTS   = 6;

    // test groups
    localparam int T_RESET = 0;
    localparam int T_UPPER = 1;
    localparam int T_ARITH = 2;
    localparam int T_LOAD  = 3;
    localparam int T_JUMP  = 4;
    localparam int T_HALT  = 5;

    logic     clk;
    logic     reset;
    word_t    inst;
    word_t    dmem_rdata;
    word_t    pc;
    word_t    dmem_addr;
    logic     dmem_ren;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     halted;

    word_t imem [IMEM_DEPTH];
    int    test_of [IMEM_DEPTH];
    word_t dmem [DMEM_DEPTH];
    word_t shadow [`NPC_REG_COUNT];
    int    errors_in [NUM_TESTS];
    string test_name [NUM_TESTS];
    int    cur_test;
    int    prog_len;
    word_t model_pc;

    bind npc_top npc_assertions u_assert (.*);

    npc_top dut (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .dmem_addr  (dmem_addr),
        .dmem_ren   (dmem_ren),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .halted     (halted)
    );

    always #20 clk = ~clk;

    function automatic int imem_slot(word_t addr);
        word_t offset;
        offset = addr - `NPC_RESET_PC;
        return int'(offset[6:2]);
    endfunction

    function automatic int dmem_slot(word_t addr);
        return int'(addr[7:2]);
    endfunction

    // both memories answer within the cycle
    assign inst       = imem[imem_slot(pc)];
    assign dmem_rdata = dmem[dmem_slot(dmem_addr)];

    function automatic word_t itype_word(opcode_t opc, reg_idx_t rd, funct3_t f3,
                                         reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t rtype_word(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {7'b0, rs2, rs1, F3_ADD, rd, OPC_OP};
    endfunction

    function automatic word_t utype_word(opcode_t opc, reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t jal_word(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic place(word_t word, int test);
        imem[prog_len] = word;
        test_of[prog_len] = test;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = `NPC_EBREAK_WORD;
            test_of[i] = T_HALT;
        end
        prog_len = 0;
        place(utype_word(OPC_LUI, 5'd1, 20'h12345), T_UPPER);
        place(utype_word(OPC_AUIPC, 5'd2, 20'h00001), T_UPPER);
        place(itype_word(OPC_OP_IMM, 5'd3, F3_ADD, 5'd0, 12'd100), T_ARITH);
        place(itype_word(OPC_OP_IMM, 5'd4, F3_ADD, 5'd3, 12'hff9), T_ARITH);
        place(rtype_word(5'd5, 5'd3, 5'd4), T_ARITH);
        // write to x0 must not stick
        place(itype_word(OPC_OP_IMM, 5'd0, F3_ADD, 5'd3, 12'd5), T_ARITH);
        place(rtype_word(5'd6, 5'd0, 5'd5), T_ARITH);
        place(utype_word(OPC_LUI, 5'd7, 20'h80000), T_LOAD);
        place(itype_word(OPC_LOAD, 5'd8, F3_LW, 5'd7, 12'd8), T_LOAD);
        place(itype_word(OPC_LOAD, 5'd9, F3_LW, 5'd7, 12'hffc), T_LOAD);
        place(rtype_word(5'd10, 5'd8, 5'd9), T_LOAD);
        place(jal_word(5'd11, 21'd8), T_JUMP);
        place(itype_word(OPC_OP_IMM, 5'd12, F3_ADD, 5'd0, 12'd1), T_JUMP);
        place(utype_word(OPC_AUIPC, 5'd13, 20'h00000), T_JUMP);
        // odd target lands on the add after the skipped slot
        place(itype_word(OPC_JALR, 5'd14, F3_JALR, 5'd13, 12'd13), T_JUMP);
        place(itype_word(OPC_OP_IMM, 5'd15, F3_ADD, 5'd0, 12'd1), T_JUMP);
        place(rtype_word(5'd15, 5'd11, 5'd14), T_JUMP);
        place(`NPC_EBREAK_WORD, T_HALT);
    endtask

    // reference behavior of one instruction
    task automatic model_exec(input word_t iw, input word_t cur_pc, output logic exp_wen,
                              output logic exp_load, output word_t exp_data,
                              output word_t exp_addr, output word_t exp_npc);
        word_t i_imm;
        word_t u_imm;
        word_t j_imm;
        word_t a;
        word_t b;
        i_imm = {{20{iw[31]}}, iw[31:20]};
        u_imm = {iw[31:12], 12'h000};
        j_imm = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        a = shadow[iw[19:15]];
        b = shadow[iw[24:20]];
        exp_wen = 1'b1;
        exp_load = 1'b0;
        exp_addr = a + i_imm;
        exp_npc = cur_pc + 32'd4;
        case (iw[6:0])
            OPC_LUI:    exp_data = u_imm;
            OPC_AUIPC:  exp_data = cur_pc + u_imm;
            OPC_OP_IMM: exp_data = a + i_imm;
            OPC_OP:     exp_data = a + b;
            OPC_JAL: begin
                exp_data = cur_pc + 32'd4;
                exp_npc = cur_pc + j_imm;
            end
            OPC_JALR: begin
                exp_data = cur_pc + 32'd4;
                exp_npc = exp_addr & ~32'h1;
            end
            OPC_LOAD: begin
                exp_load = 1'b1;
                exp_data = dmem[dmem_slot(exp_addr)];
            end
            // only ebreak is left in this program
            default: begin
                exp_wen = 1'b0;
                exp_data = '0;
                exp_npc = cur_pc;
            end
        endcase
    endtask

    task automatic check_word(string sig, word_t got, word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
            errors_in[cur_test]++;
        end
    endtask

    task automatic note_failure(string msg);
        $display("%s", msg);
        errors_in[cur_test]++;
    endtask

    task automatic report_test(int t);
        if (errors_in[t] == 0) begin
            $display("test %s: pass", test_name[t]);
        end else begin
            $display("test %s: fail with %0d errors", test_name[t], errors_in[t]);
        end
    endtask

    task automatic check_step();
        word_t iw;
        logic  exp_wen;
        logic  exp_load;
        word_t exp_data;
        word_t exp_addr;
        word_t exp_npc;
        int    slot;
        slot = imem_slot(model_pc);
        if (test_of[slot] != cur_test) begin
            report_test(cur_test);
            cur_test = test_of[slot];
        end
        iw = imem[slot];
        model_exec(iw, model_pc, exp_wen, exp_load, exp_data, exp_addr, exp_npc);
        check_word("pc", pc, model_pc);
        check_word("wb_en", wb_en, exp_wen);
        if (exp_wen) begin
            check_word("wb_rd", wb_rd, iw[11:7]);
            check_word("wb_data", wb_data, exp_data);
        end
        check_word("dmem_ren", dmem_ren, exp_load);
        if (exp_load) begin
            check_word("dmem_addr", dmem_addr, exp_addr);
        end
        if (exp_wen && iw[11:7] != 5'd0) begin
            shadow[iw[11:7]] = exp_data;
        end
        model_pc = exp_npc;
    endtask

    initial begin
        int cycles;
        int failed;
        int asrt_fails;
        void'($urandom(RAND_SEED));
        clk = 1'b0;
        reset = 1'b1;
        test_name = '{"reset", "upper", "arith", "load", "jump", "halt"};
        for (int i = 0; i < NUM_TESTS; i++) begin
            errors_in[i] = 0;
        end
        for (int i = 0; i < `NPC_REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = $urandom();
        end
        load_program();

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        cur_test = T_RESET;
        check_word("pc", pc, `NPC_RESET_PC);
        check_word("halted", halted, 1'b0);
        report_test(T_RESET);

        cur_test = T_UPPER;
        model_pc = `NPC_RESET_PC;
        cycles = 0;
        while (halted !== 1'b1 && cycles < RUN_TIMEOUT) begin
            check_step();
            cycles++;
            @(negedge clk);
        end
        if (cur_test != T_HALT) begin
            report_test(cur_test);
            cur_test = T_HALT;
        end

        if (halted !== 1'b1) begin
            note_failure($sformatf("core did not halt within %0d cycles", RUN_TIMEOUT));
        end else begin
            // pc stays on the ebreak and nothing is written
            for (int i = 0; i < HALT_WINDOW; i++) begin
                check_word("halted", halted, 1'b1);
                check_word("pc", pc, model_pc);
                check_word("wb_en", wb_en, 1'b0);
                @(negedge clk);
            end
        end
        report_test(T_HALT);

        failed = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (errors_in[i] != 0) begin
                failed++;
            end
        end
        asrt_fails = dut.u_assert.fail_count;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 NUM_TESTS, NUM_TESTS - failed, failed, asrt_fails);
        if (failed == 0 && asrt_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
